// File: project.f
logic/prbs_pkg.sv
logic/prbs_feedback.sv
logic/prbs_generator.sv
logic/prbs_checker.sv
logic/prbs_link_top.sv
test/prbs_link_asserts.sv
test/prbs_link_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module prbs_link_tb -o sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim > sim.log 2>&1

grep -q "Test failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "%Error" sim.log && { echo "Assertion failed, see sim.log"; exit 1; }
grep -q "Test passed" sim.log || { echo "No pass message, see sim.log"; exit 1; }
echo "Simulation passed"

// File: test/prbs_link_tb.sv
`timescale 1ns/1ns

module prbs_link_tb;
    import prbs_pkg::*;

    localparam int TIMEOUT_CYCLES = 80000;  // Wrap test plus the short tests
    localparam tap_set_t TAPS_MAX = {5'd4, 5'd13, 5'd15, 5'd16};  // Slot 0 holds 16
    localparam tap_set_t TAPS_ALT = {5'd0, 5'd11, 5'd0, 5'd16};   // Two unused slots

    logic        i_clk;
    logic        i_rst_n;
    logic        i_gen_enable;
    logic        i_seed_load;
    lfsr_state_t i_seed;
    tap_set_t    i_taps;
    logic        o_tx_bit;
    logic        o_tx_valid;
    logic        o_wrap;
    logic        i_rx_bit;
    logic        i_rx_valid;
    logic        i_resync;
    logic        o_locked;
    logic        o_err_strobe;
    err_count_t  o_err_count;

    // Model state
    lfsr_state_t m_state;
    lfsr_state_t m_seed;
    logic        rx_hist [0:LFSR_WIDTH-1];  // Oldest received bit first
    int          m_fill;
    err_count_t  m_err_count;
    logic        exp_tx_bit;
    logic        exp_tx_valid;
    logic        exp_wrap;
    logic        exp_err;
    int          shift_count;   // Shifts since last load
    int          wrap_at;       // Shift count at first DUT wrap
    logic        wrap_seen;
    int          seed;
    int          flips;
    int          cycle_count;
    int          error_count;
    int          period;
    err_count_t  saved_count;

    prbs_link_top dut_i (.*);

    always #4 i_clk = ~i_clk;  // 8 ns period

    // Feedback rule on a register state
    function automatic lfsr_state_t next_state(input lfsr_state_t s, input tap_set_t taps);
        logic fb;
        int   t;
        fb = s[0];
        for (int i = 0; i < TAP_COUNT; i++) begin
            t = int'(taps[i*TAP_INDEX_WIDTH +: TAP_INDEX_WIDTH]);
            if (t >= 1 && t <= LFSR_WIDTH) fb ^= s[t-1];  // Zero slot skipped
        end
        return {fb, s[LFSR_WIDTH-1:1]};
    endfunction

    // Recurrence: bit n+16 = bit n ^ bit n+t-1 per nonzero tap
    function automatic logic predict_bit(input logic h [0:LFSR_WIDTH-1], input tap_set_t taps);
        logic p;
        int   t;
        p = h[0];
        for (int i = 0; i < TAP_COUNT; i++) begin
            t = int'(taps[i*TAP_INDEX_WIDTH +: TAP_INDEX_WIDTH]);
            if (t >= 1 && t <= LFSR_WIDTH) p ^= h[t-1];
        end
        return p;
    endfunction

    // Shifts needed to return to the seed
    function automatic int compute_period(input lfsr_state_t s0, input tap_set_t taps);
        lfsr_state_t s;
        int          n;
        s = next_state(s0, taps);
        n = 1;
        while (s != s0 && n < 70000) begin
            s = next_state(s, taps);
            n++;
        end
        return n;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Output check stopped the run");
    endtask

    // One clock of stimulus, loopback channel included
    task automatic step(input logic en, input logic gaps, input logic inject);
        logic flip;
        @(posedge i_clk);
        flip = inject && o_tx_valid && (($random(seed) & 15) == 0);  // Rare bit flip
        if (flip) flips++;
        i_gen_enable <= gaps ? (($random(seed) & 3) != 0) : en;
        i_seed_load  <= 1'b0;
        i_resync     <= 1'b0;
        i_rx_bit     <= o_tx_bit ^ flip;
        i_rx_valid   <= o_tx_valid;
    endtask

    task automatic run_cycles(input int n, input logic gaps, input logic inject);
        repeat (n) step(1'b1, gaps, inject);
    endtask

    task automatic load_seed(input lfsr_state_t s);
        step(1'b1, 1'b0, 1'b0);
        i_seed_load <= 1'b1;  // Overrides the clear in step
        i_seed      <= s;
    endtask

    task automatic pulse_resync();
        step(1'b1, 1'b0, 1'b0);
        i_resync <= 1'b1;
    endtask

    // Reference model, fed with inputs as sampled at the edge
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            m_state = '1;
            m_seed = '1;
            m_fill = 0;
            m_err_count = '0;
            exp_tx_valid = 1'b0;
            exp_wrap = 1'b0;
            exp_err = 1'b0;
            shift_count = 0;
        end else begin
            exp_tx_valid = i_gen_enable && !i_seed_load;
            exp_wrap = 1'b0;
            exp_err = 1'b0;
            if (i_gen_enable && i_seed_load) begin
                m_state = i_seed;
                m_seed = i_seed;
                shift_count = 0;
            end else if (i_gen_enable) begin
                exp_tx_bit = m_state[0];
                m_state = next_state(m_state, i_taps);
                shift_count++;
                exp_wrap = (m_state == m_seed);  // Only a shift can wrap
            end
            if (i_resync) begin
                m_fill = 0;
            end else if (i_rx_valid) begin
                if (m_fill == LFSR_WIDTH) begin
                    exp_err = (i_rx_bit != predict_bit(rx_hist, i_taps));
                    if (exp_err) m_err_count++;
                end else begin
                    m_fill++;
                end
            end
            if (i_rx_valid) begin  // History shifts even on resync
                for (int i = 0; i < LFSR_WIDTH - 1; i++) rx_hist[i] = rx_hist[i+1];
                rx_hist[LFSR_WIDTH-1] = i_rx_bit;
            end
        end
    end

    // Comparison at the falling edge, away from register updates
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            assert (o_tx_valid === exp_tx_valid) else report_error("o_tx_valid wrong");
            if (exp_tx_valid) begin
                assert (o_tx_bit === exp_tx_bit) else report_error("o_tx_bit wrong");
            end
            assert (o_wrap === exp_wrap) else report_error("o_wrap wrong");
            assert (o_locked === (m_fill == LFSR_WIDTH)) else report_error("o_locked wrong");
            assert (o_err_strobe === exp_err) else report_error("o_err_strobe wrong");
            assert (o_err_count === m_err_count) else report_error("o_err_count wrong");
            if (o_wrap && !wrap_seen) begin
                wrap_seen = 1'b1;
                wrap_at = shift_count;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        seed = 39178;
        flips = 0;
        cycle_count = 0;
        error_count = 0;
        wrap_seen = 1'b0;
        wrap_at = 0;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_gen_enable = 1'b0;
        i_seed_load = 1'b0;
        i_seed = '0;
        i_taps = TAPS_MAX;
        i_rx_bit = 1'b0;
        i_rx_valid = 1'b0;
        i_resync = 1'b0;
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // Pattern under random gaps, clean loopback
        load_seed(16'hACE1);
        run_cycles(400, 1'b1, 1'b0);
        @(negedge i_clk);
        assert (o_locked && o_err_count == '0) else report_error("clean loopback not locked");

        // Injected flips
        run_cycles(400, 1'b1, 1'b1);
        run_cycles(2 * LFSR_WIDTH, 1'b0, 1'b0);  // Flipped bits leave the history
        @(negedge i_clk);
        assert (flips > 0 && o_err_count != '0) else report_error("no errors counted");

        // Resync keeps the count
        saved_count = o_err_count;
        pulse_resync();
        run_cycles(40, 1'b0, 1'b0);
        @(negedge i_clk);
        assert (o_locked && o_err_count == saved_count) else report_error("resync relock wrong");

        // Tap set with zero slots
        step(1'b0, 1'b0, 1'b0);
        i_taps   <= TAPS_ALT;
        i_resync <= 1'b1;  // Old stream bits in flight not compared
        load_seed(16'h1234);
        pulse_resync();
        run_cycles(300, 1'b1, 1'b0);
        @(negedge i_clk);
        assert (o_locked && o_err_count == saved_count) else report_error("alt taps unlocked");

        // Full period wrap
        step(1'b0, 1'b0, 1'b0);
        i_taps <= TAPS_MAX;
        period = compute_period(16'h0001, TAPS_MAX);
        wrap_seen = 1'b0;
        load_seed(16'h0001);
        while (!wrap_seen) step(1'b1, 1'b0, 1'b0);
        assert (wrap_at == period) else report_error("wrap period wrong");

        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : prbs_link_tb

// File: test/prbs_link_asserts.sv
`timescale 1ns/1ns

module prbs_link_asserts (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  o_wrap,
    input logic                  o_locked,
    input logic                  o_err_strobe,
    input prbs_pkg::err_count_t  o_err_count,
    input prbs_pkg::lfsr_state_t i_state,      // Generator register
    input prbs_pkg::lfsr_state_t i_seed_copy   // Generator stored seed
);
    import prbs_pkg::*;

    // Errors only counted once the history is full
    strobe_needs_lock: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_err_strobe |-> o_locked)
        else $error("error strobe while unlocked");

    // Wrap held only for a fixed point of the register, all bits equal
    wrap_single_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wrap && $past(o_wrap)) |->
            ((i_state == i_seed_copy) &&
             (i_state[LFSR_WIDTH-1:1] == i_state[LFSR_WIDTH-2:0])))
        else $error("wrap held longer than one cycle");

    // Counter moves only with the strobe
    count_with_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$stable(o_err_count) |-> o_err_strobe)
        else $error("error count changed without strobe");

endmodule : prbs_link_asserts

bind prbs_link_top prbs_link_asserts asserts_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .o_wrap       (o_wrap),
    .o_locked     (o_locked),
    .o_err_strobe (o_err_strobe),
    .o_err_count  (o_err_count),
    .i_state      (generator_i.state_q),
    .i_seed_copy  (generator_i.seed_q)
);

// File: logic/prbs_link_top.sv
`timescale 1ns/1ns

module prbs_link_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // Transmit side
    input  logic                  i_gen_enable,  // Generator runs while high
    input  logic                  i_seed_load,   // Honoured with i_gen_enable
    input  prbs_pkg::lfsr_state_t i_seed,
    input  prbs_pkg::tap_set_t    i_taps,        // Shared by both sides
    output logic                  o_tx_bit,
    output logic                  o_tx_valid,
    output logic                  o_wrap,
    // Receive side
    input  logic                  i_rx_bit,      // Looped back externally
    input  logic                  i_rx_valid,
    input  logic                  i_resync,
    output logic                  o_locked,
    output logic                  o_err_strobe,
    output prbs_pkg::err_count_t  o_err_count
);

    // Pattern source
    prbs_generator generator_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_gen_enable),
        .i_seed_load (i_seed_load),
        .i_seed      (i_seed),
        .i_taps      (i_taps),
        .o_tx_bit    (o_tx_bit),
        .o_tx_valid  (o_tx_valid),
        .o_wrap      (o_wrap)
    );

    // Self-synchronizing receiver, no seed needed
    prbs_checker checker_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rx_bit     (i_rx_bit),
        .i_rx_valid   (i_rx_valid),
        .i_resync     (i_resync),
        .i_taps       (i_taps),
        .o_locked     (o_locked),
        .o_err_strobe (o_err_strobe),
        .o_err_count  (o_err_count)
    );

endmodule : prbs_link_top

// File: logic/prbs_checker.sv
`timescale 1ns/1ns

module prbs_checker (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_rx_bit,      // Received stream
    input  logic                 i_rx_valid,    // Bit present this cycle
    input  logic                 i_resync,      // Restart history fill
    input  prbs_pkg::tap_set_t   i_taps,        // Same taps as the generator
    output logic                 o_locked,      // History full
    output logic                 o_err_strobe,  // One cycle per mismatch
    output prbs_pkg::err_count_t o_err_count    // Total mismatches
);
    import prbs_pkg::*;

    lfsr_state_t           history_q;     // Newest bit at the top
    logic [FILL_WIDTH-1:0] fill_q;        // Bits taken since reset or resync
    logic                  history_full;
    logic                  predicted;     // Expected next bit
    logic                  take_bit;      // Valid bit not discarded by resync
    logic                  mismatch;

    // Oldest history bit plays the role of the generator's bit 0
    prbs_feedback feedback_i (
        .i_state    (history_q),
        .i_taps     (i_taps),
        .o_feedback (predicted)
    );

    assign history_full = (fill_q == FILL_WIDTH'(LFSR_WIDTH));
    assign take_bit     = i_rx_valid & ~i_resync;
    assign mismatch     = take_bit & history_full & (i_rx_bit != predicted);  // Only once full
    assign o_locked     = history_full;                                         // Fill is registered

    // Fill and error tracking
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fill_q       <= '0;
            o_err_strobe <= 1'b0;
            o_err_count  <= '0;
        end else begin
            if (i_resync) begin
                fill_q <= '0;                     // Count survives resync
            end else if (i_rx_valid && !history_full) begin
                fill_q <= fill_q + 1'b1;          // Stops at LFSR_WIDTH
            end
            o_err_strobe <= mismatch;
            if (mismatch) begin
                o_err_count <= o_err_count + 1'b1;  // Wraps, no saturation
            end
        end
    end

    // Every received bit enters, matched or not
    always_ff @(posedge i_clk) begin
        if (i_rx_valid) begin
            history_q <= {i_rx_bit, history_q[LFSR_WIDTH-1:1]};
        end
    end

endmodule : prbs_checker

// File: logic/prbs_generator.sv
`timescale 1ns/1ns

module prbs_generator (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_enable,     // Advance while high
    input  logic                  i_seed_load,  // Needs i_enable as well
    input  prbs_pkg::lfsr_state_t i_seed,
    input  prbs_pkg::tap_set_t    i_taps,
    output logic                  o_tx_bit,     // Old state bit 0
    output logic                  o_tx_valid,   // One per shift
    output logic                  o_wrap        // State just returned to seed
);
    import prbs_pkg::*;

    lfsr_state_t state_q;     // Shift register
    lfsr_state_t seed_q;      // Last loaded seed
    lfsr_state_t state_next;  // Shifted state
    logic        feedback;
    logic        do_load;
    logic        do_shift;

    assign do_load  = i_enable & i_seed_load;   // Load wins over shift
    assign do_shift = i_enable & ~i_seed_load;

    prbs_feedback feedback_i (
        .i_state    (state_q),
        .i_taps     (i_taps),
        .o_feedback (feedback)
    );

    assign state_next = {feedback, state_q[LFSR_WIDTH-1:1]};  // Shift right, feedback on top

    // State, seed copy and strobes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= '1;      // Nonzero start
            seed_q     <= '1;
            o_tx_valid <= 1'b0;
            o_wrap     <= 1'b0;
        end else begin
            o_tx_valid <= do_shift;                              // Low during load cycle
            o_wrap     <= do_shift && (state_next == seed_q);    // Load itself never wraps
            if (do_load) begin
                state_q <= i_seed;
                seed_q  <= i_seed;
            end else if (do_shift) begin
                state_q <= state_next;
            end
        end
    end

    // Emitted bit only meaningful with o_tx_valid
    always_ff @(posedge i_clk) begin
        if (do_shift) begin
            o_tx_bit <= state_q[0];
        end
    end

endmodule : prbs_generator

// File: logic/prbs_feedback.sv
`timescale 1ns/1ns

module prbs_feedback (
    input  prbs_pkg::lfsr_state_t i_state,     // Current register state or history
    input  prbs_pkg::tap_set_t    i_taps,      // Concatenated tap slots
    output logic                  o_feedback   // Bit entering at the top
);
    import prbs_pkg::*;

    tap_index_t                 tap_slot [TAP_COUNT];  // One entry per slot
    logic [STATE_SEL_WIDTH-1:0] tap_sel  [TAP_COUNT];  // Zero-based state bit
    logic [TAP_COUNT-1:0]       tap_used;              // Slot holds a usable position

    // Split the tap set and qualify each slot
    always_comb begin
        for (int i = 0; i < TAP_COUNT; i++) begin
            tap_slot[i] = i_taps[i*TAP_INDEX_WIDTH +: TAP_INDEX_WIDTH];
            tap_used[i] = (tap_slot[i] != '0) &&
                          (tap_slot[i] <= tap_index_t'(LFSR_WIDTH));  // Beyond the register ignored
            tap_sel[i]  = STATE_SEL_WIDTH'(tap_slot[i] - 1'b1);       // 1-based to 0-based
        end
    end

    // Bit 0 always feeds back, each used tap adds its bit
    always_comb begin
        o_feedback = i_state[0];
        for (int i = 0; i < TAP_COUNT; i++) begin
            if (tap_used[i]) begin
                o_feedback ^= i_state[tap_sel[i]];
            end
        end
    end

endmodule : prbs_feedback

// File: logic/prbs_pkg.sv
package prbs_pkg;

    // Register and tap geometry
    localparam int LFSR_WIDTH      = 16;  // Shift register length
    localparam int TAP_INDEX_WIDTH = 5;   // One 1-based tap position
    localparam int TAP_COUNT       = 4;   // Tap slots in a tap set
    localparam int ERR_COUNT_WIDTH = 16;  // Checker error counter

    // Derived widths
    localparam int STATE_SEL_WIDTH = $clog2(LFSR_WIDTH);      // Bit select into the state
    localparam int FILL_WIDTH      = $clog2(LFSR_WIDTH + 1);  // Counts 0 up to LFSR_WIDTH

    // Register state, seed and received history share one shape
    typedef logic [LFSR_WIDTH-1:0] lfsr_state_t;

    // Zero marks an unused slot
    typedef logic [TAP_INDEX_WIDTH-1:0] tap_index_t;

    // Slot 0 sits in the lowest bits
    typedef logic [TAP_COUNT*TAP_INDEX_WIDTH-1:0] tap_set_t;

    typedef logic [ERR_COUNT_WIDTH-1:0] err_count_t;

endpackage : prbs_pkg
